// ==== flist.f ====
source/ifetch_pkg.sv
source/ipb_if.sv
source/fetch_timeout.sv
source/halfword_fifo.sv
source/fetch_ctrl.sv
source/issue_align.sv
source/ifetch_top.sv
tb/tb_ifetch.sv

// ==== run.sh ====
#!/bin/sh
# compile the fetch front end with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ifetch -f flist.f -o sim_ifetch
./obj_dir/sim_ifetch | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_redirect,      // one-cycle pulse
    input  logic [ifetch_pkg::XLEN-1:0] i_redirect_pc,   // bit 0 ignored
    input  logic [ifetch_pkg::XLEN-1:0] i_bus_rsp_data,
    input  logic                        i_bus_rsp_ack,
    input  logic                        i_bus_rsp_err,
    input  logic                        i_expire,        // watchdog fired
    output logic [ifetch_pkg::XLEN-1:0] o_bus_req_addr,
    output logic                        o_bus_req_re,
    output logic                        o_pending,       // to watchdog
    output logic                        o_flush,         // to issue stage
    output logic [ifetch_pkg::XLEN-1:0] o_restart_pc,
    ipb_if.writer                       lane0,           // low parcel
    ipb_if.writer                       lane1            // high parcel
);

    ifetch_pkg::fetch_state_e          state_q;
    logic [ifetch_pkg::XLEN-1:2]       fetch_pc_q;       // word address
    logic                              unaligned_q;      // skip low parcel once
    logic                              flush_q;          // redirect pending
    logic [ifetch_pkg::XLEN-1:1]       redir_pc_q;       // latched target
    logic                              redirect_pend;
    logic                              both_free;
    logic                              resp;
    logic                              rsp_err;
    logic [ifetch_pkg::XLEN-1:0]       restart_pc;
    ifetch_pkg::fetch_word_u           rsp_word;

    assign redirect_pend = flush_q | i_redirect;          // includes the pulse cycle
    assign both_free     = lane0.free & lane1.free;
    assign resp          = i_bus_rsp_ack | i_bus_rsp_err | i_expire;
    assign rsp_err       = i_bus_rsp_err | i_expire;      // expiry counts as error

    // fresh target wins over the latched one
    assign restart_pc = i_redirect ? {i_redirect_pc[ifetch_pkg::XLEN-1:1], 1'b0}
                                   : {redir_pc_q, 1'b0};

    // ==========================================================
    // redirect latch and flush level
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            redir_pc_q <= '0;                             // boot at address 0
            flush_q    <= 1'b0;
        end else begin
            if (i_redirect) begin
                redir_pc_q <= i_redirect_pc[ifetch_pkg::XLEN-1:1];
                flush_q    <= 1'b1;
            end else if (state_q == ifetch_pkg::FETCH_RESTART) begin
                flush_q    <= 1'b0;                       // lanes cleared this cycle
            end
        end
    end

    // ==========================================================
    // fetch state machine
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q     <= ifetch_pkg::FETCH_RESTART;
            fetch_pc_q  <= '0;
            unaligned_q <= 1'b0;
        end else begin
            case (state_q)
                ifetch_pkg::FETCH_RESTART: begin
                    fetch_pc_q  <= restart_pc[ifetch_pkg::XLEN-1:2];
                    unaligned_q <= restart_pc[1];         // start in high parcel
                    state_q     <= ifetch_pkg::FETCH_REQUEST;
                end
                ifetch_pkg::FETCH_REQUEST: begin
                    if (redirect_pend)
                        state_q <= ifetch_pkg::FETCH_RESTART;  // no point fetching
                    else if (both_free)
                        state_q <= ifetch_pkg::FETCH_PENDING;
                end
                ifetch_pkg::FETCH_PENDING: begin
                    if (resp) begin
                        fetch_pc_q  <= fetch_pc_q + 1'b1;
                        unaligned_q <= 1'b0;
                        state_q     <= redirect_pend ? ifetch_pkg::FETCH_RESTART
                                                     : ifetch_pkg::FETCH_REQUEST;
                    end
                end
                default: state_q <= ifetch_pkg::FETCH_RESTART;
            endcase
        end
    end

    // expired fetch delivers zero data
    always_comb begin
        rsp_word.word = i_expire ? '0 : i_bus_rsp_data;
    end

    assign o_bus_req_addr = {fetch_pc_q, 2'b00};
    assign o_bus_req_re   = (state_q == ifetch_pkg::FETCH_REQUEST) & both_free & ~redirect_pend;
    assign o_pending      = (state_q == ifetch_pkg::FETCH_PENDING);
    assign o_flush        = redirect_pend;
    assign o_restart_pc   = restart_pc;

    // lane writes, shared error bit
    assign lane0.clear = (state_q == ifetch_pkg::FETCH_RESTART);
    assign lane1.clear = (state_q == ifetch_pkg::FETCH_RESTART);
    assign lane0.wdata = '{rsp_err, rsp_word.parcels.lo};
    assign lane1.wdata = '{rsp_err, rsp_word.parcels.hi};
    assign lane0.we    = o_pending & resp & ~unaligned_q;   // low parcel skipped
    assign lane1.we    = o_pending & resp;

endmodule

// ==== source/fetch_timeout.sv ====
`timescale 1ns/1ns

module fetch_timeout #(
    parameter int TIMEOUT_CYCLES = 16                    // cycles before forced error
) (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_pending,                              // fetch in FETCH_PENDING
    output logic o_expire                                // one-cycle pulse
);

    localparam int                CNT_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0]  LAST  = CNT_W'(TIMEOUT_CYCLES - 1);
    localparam logic [CNT_W-1:0]  SAT   = CNT_W'(TIMEOUT_CYCLES);

    logic [CNT_W-1:0] cnt_q;                             // cycles spent waiting

    // counts while pending, parks at SAT once fired
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            cnt_q <= '0;
        end else if (!i_pending) begin
            cnt_q <= '0;                                 // idle between requests
        end else if (cnt_q != SAT) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // fires on the TIMEOUT_CYCLES-th waiting cycle
    assign o_expire = i_pending & (cnt_q == LAST);

endmodule

// ==== source/halfword_fifo.sv ====
`timescale 1ns/1ns

module halfword_fifo #(
    parameter int BUFFER_DEPTH = 4                       // power of two, >= 2
) (
    input  logic  i_clk,
    input  logic  i_rstn,
    ipb_if.buffer lane
);

    localparam int AW = $clog2(BUFFER_DEPTH);            // index width

    ifetch_pkg::ipb_entry_t mem [BUFFER_DEPTH];          // ring storage
    logic [AW:0]            wptr_q;                      // msb is wrap bit
    logic [AW:0]            rptr_q;
    logic                   same_idx;
    logic                   same_wrap;

    // ==========================================================
    // storage
    // ==========================================================
    always_ff @(posedge i_clk) begin
        if (lane.we)
            mem[wptr_q[AW-1:0]] <= lane.wdata;
    end

    // ==========================================================
    // pointers
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else if (lane.clear) begin
            wptr_q <= '0;                                // drop everything
            rptr_q <= '0;
        end else begin
            if (lane.we)
                wptr_q <= wptr_q + 1'b1;
            if (lane.re)
                rptr_q <= rptr_q + 1'b1;
        end
    end

    assign same_idx  = (wptr_q[AW-1:0] == rptr_q[AW-1:0]);
    assign same_wrap = (wptr_q[AW] == rptr_q[AW]);

    assign lane.avail = ~(same_idx & same_wrap);          // not empty
    assign lane.free  = ~(same_idx & ~same_wrap);         // not full

    // async read of the oldest entry
    assign lane.rdata = mem[rptr_q[AW-1:0]];

endmodule

// ==== source/ifetch_pkg.sv ====
package ifetch_pkg;

    // ==========================================================
    // widths and encodings
    // ==========================================================
    localparam int XLEN    = 32;                 // address / data width
    localparam int HWORD_W = 16;                 // one instruction parcel

    localparam logic [1:0] UNCOMP_MARK = 2'b11;  // low bits of a 32-bit instr

    // fetch state machine
    typedef enum logic [1:0] {
        FETCH_RESTART = 2'b00,                   // load new start address
        FETCH_REQUEST = 2'b01,                   // issue bus read
        FETCH_PENDING = 2'b10                    // wait for ack / err / expire
    } fetch_state_e;

    // one prefetch buffer slot
    typedef struct packed {
        logic               err;                 // bus error on this parcel
        logic [HWORD_W-1:0] parcel;              // raw 16-bit parcel
    } ipb_entry_t;

    // bus word, seen whole or as two parcels
    typedef union packed {
        logic [XLEN-1:0] word;                   // full instruction word
        struct packed {
            logic [HWORD_W-1:0] hi;              // lane 1
            logic [HWORD_W-1:0] lo;              // lane 0
        } parcels;
    } fetch_word_u;

endpackage

// ==== source/ifetch_top.sv ====
`timescale 1ns/1ns

module ifetch_top #(
    parameter int BUFFER_DEPTH   = 4,                     // entries per lane
    parameter int TIMEOUT_CYCLES = 16                     // watchdog limit
) (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_redirect,
    input  logic [ifetch_pkg::XLEN-1:0] i_redirect_pc,
    output logic [ifetch_pkg::XLEN-1:0] o_bus_req_addr,
    output logic                        o_bus_req_re,
    input  logic [ifetch_pkg::XLEN-1:0] i_bus_rsp_data,
    input  logic                        i_bus_rsp_ack,
    input  logic                        i_bus_rsp_err,
    output logic                        o_issue_valid,
    output logic [ifetch_pkg::XLEN-1:0] o_issue_instr,
    output logic                        o_issue_compressed,
    output logic                        o_issue_err,
    output logic [ifetch_pkg::XLEN-1:0] o_issue_pc,
    input  logic                        i_issue_ack
);

    logic                        expire;                  // watchdog pulse
    logic                        pending;                 // fetch waiting on bus
    logic                        flush;
    logic [ifetch_pkg::XLEN-1:0] restart_pc;

    ipb_if lane0_if ();                                   // low half-words
    ipb_if lane1_if ();                                   // high half-words

    // ==========================================================
    // fetch side
    // ==========================================================
    fetch_ctrl u_fetch_ctrl (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_bus_rsp_data (i_bus_rsp_data),
        .i_bus_rsp_ack  (i_bus_rsp_ack),
        .i_bus_rsp_err  (i_bus_rsp_err),
        .i_expire       (expire),
        .o_bus_req_addr (o_bus_req_addr),
        .o_bus_req_re   (o_bus_req_re),
        .o_pending      (pending),
        .o_flush        (flush),
        .o_restart_pc   (restart_pc),
        .lane0          (lane0_if),
        .lane1          (lane1_if)
    );

    fetch_timeout #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_fetch_timeout (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_pending (pending),
        .o_expire  (expire)
    );

    // ==========================================================
    // prefetch lanes and issue
    // ==========================================================
    halfword_fifo #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_ipb0 (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .lane   (lane0_if)
    );

    halfword_fifo #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_ipb1 (
        .i_clk  (i_clk),
        .i_rstn (i_rstn),
        .lane   (lane1_if)
    );

    issue_align u_issue_align (
        .i_clk              (i_clk),
        .i_rstn             (i_rstn),
        .i_flush            (flush),
        .i_restart_pc       (restart_pc),
        .i_issue_ack        (i_issue_ack),
        .lane0              (lane0_if),
        .lane1              (lane1_if),
        .o_issue_valid      (o_issue_valid),
        .o_issue_instr      (o_issue_instr),
        .o_issue_compressed (o_issue_compressed),
        .o_issue_err        (o_issue_err),
        .o_issue_pc         (o_issue_pc)
    );

endmodule

// ==== source/ipb_if.sv ====
`timescale 1ns/1ns

interface ipb_if;

    logic                   clear;   // sync flush of the lane
    ifetch_pkg::ipb_entry_t wdata;   // parcel + error from fetch
    logic                   we;      // write strobe
    logic                   free;    // at least one empty slot
    ifetch_pkg::ipb_entry_t rdata;   // oldest entry
    logic                   avail;   // rdata valid
    logic                   re;      // pop strobe

    // fetch side
    modport writer (output clear, output wdata, output we, input free);

    // the FIFO itself
    modport buffer (
        input  clear,
        input  wdata,
        input  we,
        input  re,
        output free,
        output rdata,
        output avail
    );

    // issue side
    modport reader (input rdata, input avail, output re);

endinterface

// ==== source/issue_align.sv ====
`timescale 1ns/1ns

module issue_align (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  logic                        i_flush,          // redirect in progress
    input  logic [ifetch_pkg::XLEN-1:0] i_restart_pc,
    input  logic                        i_issue_ack,
    ipb_if.reader                       lane0,            // low parcels
    ipb_if.reader                       lane1,            // high parcels
    output logic                        o_issue_valid,
    output logic [ifetch_pkg::XLEN-1:0] o_issue_instr,
    output logic                        o_issue_compressed,
    output logic                        o_issue_err,
    output logic [ifetch_pkg::XLEN-1:0] o_issue_pc
);

    logic                        align_q;                 // next parcel in lane 1
    logic [ifetch_pkg::XLEN-1:0] pc_q;
    ifetch_pkg::ipb_entry_t      first;                   // parcel at pc
    ifetch_pkg::ipb_entry_t      second;                  // parcel at pc+2
    logic                        first_avail;
    logic                        second_avail;
    logic                        is_comp;
    logic                        ready;
    logic                        retire;
    logic [ifetch_pkg::XLEN-1:0] pc_step;
    ifetch_pkg::fetch_word_u     issue_word;

    // ==========================================================
    // lane selection
    // ==========================================================
    always_comb begin
        if (align_q) begin
            first        = lane1.rdata;                   // high half of word n
            second       = lane0.rdata;                   // low half of word n+1
            first_avail  = lane1.avail;
            second_avail = lane0.avail;
        end else begin
            first        = lane0.rdata;
            second       = lane1.rdata;
            first_avail  = lane0.avail;
            second_avail = lane1.avail;
        end
    end

    // length detection
    assign is_comp = (first.parcel[1:0] != ifetch_pkg::UNCOMP_MARK);
    assign ready   = is_comp ? first_avail : (first_avail & second_avail);

    // compressed parcel is zero-extended
    always_comb begin
        issue_word.parcels.lo = first.parcel;
        issue_word.parcels.hi = is_comp ? {ifetch_pkg::HWORD_W{1'b0}} : second.parcel;
    end

    assign o_issue_valid      = ready & ~i_flush;        // nothing leaves during flush
    assign o_issue_instr      = issue_word.word;
    assign o_issue_compressed = is_comp;
    assign o_issue_err        = first.err | (~is_comp & second.err);
    assign o_issue_pc         = pc_q;

    assign retire  = o_issue_valid & i_issue_ack;
    assign pc_step = is_comp ? ifetch_pkg::XLEN'(2) : ifetch_pkg::XLEN'(4);

    // first lane always popped, the other only for 32-bit
    assign lane0.re = retire & (~align_q | ~is_comp);
    assign lane1.re = retire & (align_q | ~is_comp);

    // ==========================================================
    // pc and alignment tracking
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            pc_q    <= '0;
            align_q <= 1'b0;
        end else if (i_flush) begin
            pc_q    <= {i_restart_pc[ifetch_pkg::XLEN-1:1], 1'b0};
            align_q <= i_restart_pc[1];                   // half-word start
        end else if (retire) begin
            pc_q    <= pc_q + pc_step;
            align_q <= align_q ^ is_comp;                 // 16-bit flips the lane
        end
    end

endmodule

// ==== tb/tb_ifetch.sv ====
`timescale 1ns/1ns

module tb_ifetch;

    localparam int          TIMEOUT_CYCLES = 16;             // DUT watchdog limit
    localparam int          RESET_CYCLES   = 8;
    localparam int          N_FIRST        = 150;            // retires before redirect
    localparam int          N_TOTAL        = 300;
    localparam int          TAB_LEN        = 4096;           // random delay / hold tables
    localparam int          MAX_CYCLES     = 20 * N_TOTAL + 2 * TIMEOUT_CYCLES + RESET_CYCLES;
    localparam logic [7:0]  ERR_WORD       = 8'd30;          // answers with bus error
    localparam logic [7:0]  SILENT_WORD    = 8'd60;          // never answers
    localparam logic [31:0] REDIR_PC       = 32'h0000_0202;  // high half of word 128

    logic        i_clk = 1'b0;
    logic        i_rstn;
    logic        i_redirect;
    logic [31:0] i_redirect_pc;
    logic [31:0] o_bus_req_addr;
    logic        o_bus_req_re;
    logic [31:0] i_bus_rsp_data;
    logic        i_bus_rsp_ack;
    logic        i_bus_rsp_err;
    logic        o_issue_valid;
    logic [31:0] o_issue_instr;
    logic        o_issue_compressed;
    logic        o_issue_err;
    logic [31:0] o_issue_pc;
    logic        i_issue_ack;

    logic [31:0] mem [256];                                  // instruction image
    int          delay_tab [TAB_LEN];                        // ack delay per request
    int          hold_tab [TAB_LEN];                         // ack hold per slot
    logic [31:0] exp_pc = '0;                                // boot address
    int          n_retired = 0;
    int          n_mismatch = 0;
    int          n_other = 0;
    int          n_err_seen = 0;
    int          n_straddle = 0;

    ifetch_top #(.BUFFER_DEPTH(4), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) UUT (.*);

    always #2 i_clk = ~i_clk;                                // 4 ns period

    // ============================================================
    // reference model
    // ============================================================
    function automatic logic [15:0] rand_parcel();
        logic [15:0] p;
        p = 16'($urandom);
        if ($urandom_range(1, 0) == 1)
            p[1:0] = 2'b11;                                  // 32-bit start
        else
            p[1:0] = 2'($urandom_range(2, 0));               // compressed
        return p;
    endfunction

    function automatic logic [15:0] parcel_at(input logic [31:0] pc);
        logic [31:0] word;
        word = (pc[9:2] == SILENT_WORD) ? 32'h0 : mem[pc[9:2]];  // expiry gives zeros
        return pc[1] ? word[31:16] : word[15:0];
    endfunction

    function automatic logic parcel_err(input logic [31:0] pc);
        return (pc[9:2] == ERR_WORD) || (pc[9:2] == SILENT_WORD);
    endfunction

    function automatic void predict_instr(input logic [31:0] pc, output logic [31:0] instr,
                                          output logic comp, output logic err);
        logic [15:0] p0;
        logic [15:0] p1;
        p0    = parcel_at(pc);
        p1    = parcel_at(pc + 32'd2);
        comp  = (p0[1:0] != 2'b11);
        instr = comp ? {16'h0, p0} : {p1, p0};               // zero-extended if 16-bit
        err   = parcel_err(pc) | (~comp & parcel_err(pc + 32'd2));
    endfunction

    task automatic report_mismatch(input string msg);
        n_mismatch++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    // ============================================================
    // bus memory model
    // ============================================================
    initial begin : bus_model
        logic [31:0] addr;
        int          req_idx;
        i_bus_rsp_ack  = 1'b0;
        i_bus_rsp_err  = 1'b0;
        i_bus_rsp_data = '0;
        req_idx        = 0;
        forever begin
            @(negedge i_clk);
            if (i_rstn && o_bus_req_re) begin
                addr = o_bus_req_addr;
                @(posedge i_clk);                            // now in pending
                repeat (delay_tab[req_idx % TAB_LEN]) @(posedge i_clk);
                req_idx++;
                if (addr[9:2] != SILENT_WORD) begin          // silent word left to expire
                    #1;
                    i_bus_rsp_data = mem[addr[9:2]];
                    i_bus_rsp_ack  = (addr[9:2] != ERR_WORD);
                    i_bus_rsp_err  = (addr[9:2] == ERR_WORD);
                    @(posedge i_clk);
                    #1;
                    i_bus_rsp_ack  = 1'b0;
                    i_bus_rsp_err  = 1'b0;
                end
            end
        end
    end

    // issue ack with random holds of up to 10 cycles
    initial begin : ack_driver
        int hold_left;
        int hold_idx;
        i_issue_ack = 1'b0;
        hold_left   = 0;
        hold_idx    = 0;
        @(posedge i_rstn);
        forever begin
            @(posedge i_clk);
            #1;
            if (hold_left > 0) begin
                i_issue_ack = 1'b0;
                hold_left--;
            end else begin
                i_issue_ack = 1'b1;
                hold_left   = hold_tab[hold_idx % TAB_LEN];
                hold_idx++;
            end
        end
    end

    // ============================================================
    // retire checker
    // ============================================================
    always @(negedge i_clk) begin : compare_issue
        logic [31:0] e_instr;
        logic        e_comp;
        logic        e_err;
        if (i_redirect) begin
            exp_pc = REDIR_PC;                               // new stream starts here
        end else if (i_rstn && o_issue_valid && i_issue_ack) begin
            predict_instr(exp_pc, e_instr, e_comp, e_err);
            if (o_issue_pc !== exp_pc)
                report_mismatch($sformatf("pc %h, expected %h", o_issue_pc, exp_pc));
            if (o_issue_instr !== e_instr)
                report_mismatch($sformatf("instr %h at pc %h, expected %h",
                                          o_issue_instr, exp_pc, e_instr));
            if (o_issue_compressed !== e_comp)
                report_mismatch($sformatf("compressed %b at pc %h, expected %b",
                                          o_issue_compressed, exp_pc, e_comp));
            if (o_issue_err !== e_err)
                report_mismatch($sformatf("err %b at pc %h, expected %b",
                                          o_issue_err, exp_pc, e_err));
            if (o_issue_err)
                n_err_seen++;
            if (!o_issue_compressed && o_issue_pc[1])
                n_straddle++;                                // crosses a word boundary
            exp_pc = exp_pc + (e_comp ? 32'd2 : 32'd4);
            n_retired++;
        end
    end

    // hard cycle limit
    initial begin : run_limit
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        n_other++;
        $display("Timeout: %0d of %0d instructions retired after %0d cycles",
                 n_retired, N_TOTAL, cycles);
        $display("Done: %0d retired, %0d mismatches, %0d other errors",
                 n_retired, n_mismatch, n_other);
        $display("TEST FAIL");
        $finish;
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main_seq
        int i;
        i_rstn        = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        void'($urandom(32'h9d9d_be83));
        for (i = 0; i < 256; i++)
            mem[i] = {rand_parcel(), rand_parcel()};
        mem[128][17:16] = 2'b11;                             // redirect target is 32-bit
        for (i = 0; i < TAB_LEN; i++) begin
            delay_tab[i] = $urandom_range(3, 0);
            hold_tab[i]  = ($urandom_range(3, 0) == 0) ? $urandom_range(10, 1) : 0;
        end
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;
        wait (n_retired == N_FIRST);
        @(posedge i_clk);
        #1;
        i_redirect    = 1'b1;
        i_redirect_pc = REDIR_PC | 32'h1;                    // bit 0 must be dropped
        @(posedge i_clk);
        #1;
        i_redirect = 1'b0;
        wait (n_retired == N_TOTAL);
        repeat (4) @(posedge i_clk);
        if (n_err_seen < 3) begin
            $display("Error: only %0d instructions retired with the error flag", n_err_seen);
            n_other++;
        end
        if (n_straddle == 0) begin
            $display("Error: no 32-bit instruction crossed a word boundary");
            n_other++;
        end
        $display("Done: %0d retired, %0d mismatches, %0d other errors",
                 n_retired, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
